//--- common/sfm_macros.svh
// Serial flash front end constants: channel count, CSR offsets and reset values
`ifndef SFM_MACROS_SVH
`define SFM_MACROS_SVH

// Channel count
`define SFM_NUM			3

// Reset values
`define SFM_DIV_RST		8'd4	// SCLK half period of 5 clocks
`define SFM_SEL_RST		2'd0

// --------------------------------------------------
// CSR offsets
// --------------------------------------------------
`define SFM_REG_DIV		8'h0C	// One divisor byte per channel
`define SFM_REG_WD0		8'h14
`define SFM_REG_EN		8'h18	// Start bits, self clearing on done
`define SFM_REG_CS		8'h1C
`define SFM_REG_WD1		8'h24
`define SFM_REG_WD2		8'h28
`define SFM_REG_DONE	8'h30	// Sticky, any write clears
`define SFM_REG_SEL		8'h34
`define SFM_REG_RD0		8'h90
`define SFM_REG_RD1		8'h94
`define SFM_REG_RD2		8'h98

`endif

//--- common/SfmPkg.sv
// Shared types of the serial flash front end: widths, channel command and response, SPI pins
`default_nettype none

`include "sfm_macros.svh"

package SfmPkg;

	typedef logic [7:0]				sfmByteT;		// SPI data byte
	typedef logic [7:0]				sfmDivT;		// Half period is divisor+1 clocks
	typedef logic [7:0]				csrAdrsT;
	typedef logic [31:0]			apbDataT;
	typedef logic [1:0]				devSelT;
	typedef logic [`SFM_NUM-1:0]	sfmChMaskT;		// One bit per channel

	// CSR to engine
	typedef struct packed {
		sfmByteT	wd;
		sfmDivT		div;
		logic		start;		// Single cycle request
		logic		csLevel;	// 1 = deasserted
	} sfmCmdT;

	// Engine to CSR
	typedef struct packed {
		sfmByteT	rd;
		logic		done;
	} sfmRspT;

	typedef struct packed {
		logic		sclk;
		logic		mosi;
		logic		csN;
	} spiPinT;

	typedef enum logic [1:0] {idle, shift, finish} sfmStateT;

endpackage

`default_nettype wire

//--- csr/SfmCsr.sv
// APB register block that issues byte commands to the channels and collects their results
`timescale 1ns/1ps
`default_nettype none

`include "sfm_macros.svh"

module SfmCsr (
	input  wire logic				iSCLK,
	input  wire logic				iSRST,
	// APB slave
	input  wire logic				psel,
	input  wire logic				penable,
	input  wire logic				pwrite,
	input  wire SfmPkg::csrAdrsT	paddr,
	input  wire SfmPkg::apbDataT	pwdata,
	output SfmPkg::apbDataT			prdata,
	output logic					pready,
	output logic					pslverr,
	// Channels
	output SfmPkg::sfmCmdT			cmd [`SFM_NUM],
	input  wire SfmPkg::sfmRspT		rsp [`SFM_NUM],
	output SfmPkg::devSelT			devSel
);

	// Per channel byte offsets
	localparam SfmPkg::csrAdrsT wdAdrs [`SFM_NUM] = '{`SFM_REG_WD0, `SFM_REG_WD1, `SFM_REG_WD2};
	localparam SfmPkg::csrAdrsT rdAdrs [`SFM_NUM] = '{`SFM_REG_RD0, `SFM_REG_RD1, `SFM_REG_RD2};

	SfmPkg::sfmByteT	wdReg [`SFM_NUM];
	SfmPkg::sfmDivT		divReg [`SFM_NUM];
	SfmPkg::sfmByteT	rdReg [`SFM_NUM];	// Captured bytes
	SfmPkg::sfmChMaskT	enReg;
	SfmPkg::sfmChMaskT	csReg;
	SfmPkg::sfmChMaskT	doneReg;
	SfmPkg::sfmChMaskT	startReg;
	SfmPkg::devSelT		selReg;

	SfmPkg::apbDataT	rdWord;
	logic				mapped;
	logic				wrAcc;

	// --------------------------------------------------
	// Address decode and read word
	// --------------------------------------------------
	always_comb
	begin
		rdWord = '0;
		mapped = 1'b0;
		case (paddr)
			`SFM_REG_DIV:
			begin
				mapped = 1'b1;
				for (int i = 0; i < `SFM_NUM; i++)
				begin
					rdWord[8*i +: 8] = divReg[i];
				end
			end
			`SFM_REG_EN:
			begin
				mapped = 1'b1;
				rdWord[`SFM_NUM-1:0] = enReg;
			end
			`SFM_REG_CS:
			begin
				mapped = 1'b1;
				rdWord[`SFM_NUM-1:0] = csReg;
			end
			`SFM_REG_DONE:
			begin
				mapped = 1'b1;
				rdWord[`SFM_NUM-1:0] = doneReg;
			end
			`SFM_REG_SEL:
			begin
				mapped = 1'b1;
				rdWord[1:0] = selReg;
			end
			default:
			begin
				mapped = 1'b0;
			end
		endcase
		// Byte registers sit at scattered offsets
		for (int i = 0; i < `SFM_NUM; i++)
		begin
			if (paddr == wdAdrs[i])
			begin
				mapped = 1'b1;
				rdWord = SfmPkg::apbDataT'(wdReg[i]);
			end
			if (paddr == rdAdrs[i])
			begin
				mapped = 1'b1;
				rdWord = SfmPkg::apbDataT'(rdReg[i]);
			end
		end
	end

	// Zero wait state slave
	assign pready  = psel && penable;
	assign pslverr = psel && penable && !mapped;
	assign wrAcc   = psel && penable && pwrite && mapped;

	// Read data settles during the setup phase
	always_ff @(posedge iSCLK)
	begin
		if (psel && !penable)
		begin
			prdata <= rdWord;
		end
	end

	// --------------------------------------------------
	// Writable registers and channel status
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			for (int i = 0; i < `SFM_NUM; i++)
			begin
				wdReg[i]  <= '0;
				divReg[i] <= `SFM_DIV_RST;
				rdReg[i]  <= '0;
			end
			enReg    <= '0;
			csReg    <= '1;		// All chip-selects deasserted
			doneReg  <= '0;
			startReg <= '0;
			selReg   <= `SFM_SEL_RST;
		end
		else
		begin
			for (int i = 0; i < `SFM_NUM; i++)
			begin
				if (wrAcc && paddr == wdAdrs[i])
					wdReg[i] <= pwdata[7:0];
				if (wrAcc && paddr == `SFM_REG_DIV)
					divReg[i] <= pwdata[8*i +: 8];
				// Done wins over a clear in the same cycle
				if (rsp[i].done)
				begin
					rdReg[i]   <= rsp[i].rd;
					doneReg[i] <= 1'b1;
					enReg[i]   <= 1'b0;
				end
				else
				begin
					if (wrAcc && paddr == `SFM_REG_DONE)
						doneReg[i] <= 1'b0;
					if (wrAcc && paddr == `SFM_REG_EN && pwdata[i])
						enReg[i] <= 1'b1;
				end
				startReg[i] <= wrAcc && (paddr == `SFM_REG_EN) && pwdata[i];	// One cycle pulse
			end
			if (wrAcc && paddr == `SFM_REG_CS)
				csReg <= pwdata[`SFM_NUM-1:0];
			if (wrAcc && paddr == `SFM_REG_SEL)
				selReg <= pwdata[1:0];
		end
	end

	always_comb
	begin
		for (int i = 0; i < `SFM_NUM; i++)
		begin
			cmd[i] = '{wd: wdReg[i], div: divReg[i], start: startReg[i], csLevel: csReg[i]};
		end
	end

	assign devSel = selReg;

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	apbRespOnlyInAccess: assert property (@(posedge iSCLK) disable iff (iSRST)
		(pready || pslverr) |-> (psel && penable))
		else $error("pready or pslverr outside access phase");

	// Registered read data relies on access following setup
	apbSetupThenAccess: assert property (@(posedge iSCLK) disable iff (iSRST)
		(psel && !penable) |=> (psel && penable))
		else $error("APB setup phase not followed by access phase");

endmodule

`default_nettype wire

//--- channel/SfmByteEngine.sv
// SPI mode 0 byte engine: divided SCLK, MSB first shift out and capture of the returned byte
`timescale 1ns/1ps
`default_nettype none

module SfmByteEngine (
	input  wire logic				iSCLK,
	input  wire logic				iSRST,
	input  wire SfmPkg::sfmCmdT		cmd,
	input  wire logic				miso,
	output SfmPkg::sfmRspT			rsp,
	output SfmPkg::spiPinT			pins
);

	SfmPkg::sfmStateT	state;
	SfmPkg::sfmDivT		divReg;		// Divisor held for the whole byte
	SfmPkg::sfmDivT		divCnt;
	logic [3:0]			edgeCnt;	// 16 SCLK edges per byte
	logic				sclkReg;
	SfmPkg::sfmByteT	txShift;
	SfmPkg::sfmByteT	rxShift;
	logic				halfTick;

	// End of one SCLK half period
	assign halfTick = (state == SfmPkg::shift) && (divCnt == divReg);

	// --------------------------------------------------
	// Control FSM and SCLK generation
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state   <= SfmPkg::idle;
			divCnt  <= '0;
			edgeCnt <= '0;
			sclkReg <= 1'b0;
			txShift <= '0;
		end
		else
		begin
			case (state)
				SfmPkg::idle:
				begin
					if (cmd.start)
					begin
						state   <= SfmPkg::shift;
						divCnt  <= '0;
						edgeCnt <= '0;
						txShift <= cmd.wd;		// MSB on MOSI before the first rising edge
					end
				end
				SfmPkg::shift:
				begin
					if (halfTick)
					begin
						divCnt  <= '0;
						sclkReg <= ~sclkReg;
						edgeCnt <= edgeCnt + 4'd1;
						if (sclkReg)
						begin
							// Falling edge, next bit out
							txShift <= {txShift[6:0], 1'b0};
							if (edgeCnt == 4'd15)
								state <= SfmPkg::finish;
						end
					end
					else
					begin
						divCnt <= divCnt + 8'd1;
					end
				end
				SfmPkg::finish:
				begin
					state <= SfmPkg::idle;	// Single done cycle
				end
				default:
				begin
					state <= SfmPkg::idle;
				end
			endcase
		end
	end

	// Divisor latch and MISO capture on rising edges
	always_ff @(posedge iSCLK)
	begin
		if (state == SfmPkg::idle && cmd.start)
			divReg <= cmd.div;
		if (halfTick && !sclkReg)
			rxShift <= {rxShift[6:0], miso};
	end

	assign rsp.rd    = rxShift;
	assign rsp.done  = (state == SfmPkg::finish);
	assign pins.sclk = sclkReg;
	assign pins.mosi = txShift[7];
	assign pins.csN  = cmd.csLevel;		// CPU frames multi-byte commands

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	sclkLowInIdle: assert property (@(posedge iSCLK) disable iff (iSRST)
		(state == SfmPkg::idle) |-> !pins.sclk)
		else $error("sclk high while engine idle");

	donePulseOneCycle: assert property (@(posedge iSCLK) disable iff (iSRST)
		rsp.done |=> !rsp.done)
		else $error("done longer than one cycle");

	noStartWhileBusy: assert property (@(posedge iSCLK) disable iff (iSRST)
		cmd.start |-> (state == SfmPkg::idle))
		else $error("start while transfer in progress, ignored");

endmodule

`default_nettype wire

//--- source/SfmPinMux.sv
// SPI pad multiplexer: puts the selected channel on the shared pins and gates the chip-selects
`timescale 1ns/1ps
`default_nettype none

`include "sfm_macros.svh"

module SfmPinMux (
	input  wire SfmPkg::devSelT		devSel,
	input  wire SfmPkg::spiPinT		chPins [`SFM_NUM],
	output logic					chMiso [`SFM_NUM],
	output logic					sclk,
	output logic					mosi,
	output logic [`SFM_NUM-1:0]		csN,	// One per device
	input  wire logic				miso
);

	// --------------------------------------------------
	// Routing
	// --------------------------------------------------
	always_comb
	begin
		// Nothing selected by default
		sclk = 1'b0;
		mosi = 1'b0;
		csN  = '1;
		for (int i = 0; i < `SFM_NUM; i++)
		begin
			chMiso[i] = 1'b0;
			if (devSel == SfmPkg::devSelT'(i))
			begin
				sclk      = chPins[i].sclk;
				mosi      = chPins[i].mosi;
				csN[i]    = chPins[i].csN;
				chMiso[i] = miso;	// Only the owner sees MISO
			end
		end
	end

	// Shared bus, never two devices framed at once
	always_comb
	begin
		csOneHot: assert final ($onehot0(~csN))
			else $error("more than one csN low: csN=%h", csN);
	end

endmodule

`default_nettype wire

//--- source/SfmTop.sv
// Serial flash front end top: APB register block, per channel byte engines and SPI pin multiplexer
`timescale 1ns/1ps
`default_nettype none

`include "sfm_macros.svh"

module SfmTop (
	input  wire logic				iSCLK,
	input  wire logic				iSRST,
	// APB
	input  wire logic				psel,
	input  wire logic				penable,
	input  wire logic				pwrite,
	input  wire SfmPkg::csrAdrsT	paddr,
	input  wire SfmPkg::apbDataT	pwdata,
	output SfmPkg::apbDataT			prdata,
	output logic					pready,
	output logic					pslverr,
	// SPI pads
	output logic					sclk,
	output logic					mosi,
	output logic [`SFM_NUM-1:0]		csN,
	input  wire logic				miso
);

	SfmPkg::sfmCmdT		cmd [`SFM_NUM];
	SfmPkg::sfmRspT		rsp [`SFM_NUM];
	SfmPkg::spiPinT		chPins [`SFM_NUM];
	logic				chMiso [`SFM_NUM];
	SfmPkg::devSelT		devSel;

	SfmCsr uCsr (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cmd(cmd), .rsp(rsp), .devSel(devSel)
	);

	// One engine per channel
	for (genvar i = 0; i < `SFM_NUM; i++)
	begin : gEngine
		SfmByteEngine uEngine (
			.iSCLK(iSCLK), .iSRST(iSRST),
			.cmd(cmd[i]), .miso(chMiso[i]),
			.rsp(rsp[i]), .pins(chPins[i])
		);
	end

	SfmPinMux uPinMux (
		.devSel(devSel), .chPins(chPins), .chMiso(chMiso),
		.sclk(sclk), .mosi(mosi), .csN(csN), .miso(miso)
	);

endmodule

`default_nettype wire

//--- tests/SfmFlashModel.sv
// Behavioral SPI mode 0 flash slave that answers each byte with the complement of the previous one
`timescale 1ns/1ps
`default_nettype none

module SfmFlashModel (
	input  wire logic			csN,
	input  wire logic			sclk,
	input  wire logic			mosi,
	output wire					miso,
	output SfmPkg::sfmByteT		lastRx,
	output int					rxCount
);

	SfmPkg::sfmByteT	rxShift;
	SfmPkg::sfmByteT	txShift;
	SfmPkg::sfmByteT	nextTx;
	int					bitCnt;
	logic				byteEnd;

	initial
	begin
		rxShift = '0;
		txShift = 8'hA5;		// First answer
		nextTx  = 8'hA5;
		bitCnt  = 0;
		byteEnd = 1'b0;
		lastRx  = '0;
		rxCount = 0;
	end

	// Sample MOSI on rising edges, MSB first
	always @(posedge sclk)
	begin
		if (!csN)
		begin
			rxShift = {rxShift[6:0], mosi};
			bitCnt  = bitCnt + 1;
			if (bitCnt == 8)
			begin
				lastRx  = rxShift;
				rxCount = rxCount + 1;
				nextTx  = ~rxShift;	// Answer for the next byte
				bitCnt  = 0;
				byteEnd = 1'b1;
			end
		end
	end

	// Next bit out on falling edges
	always @(negedge sclk)
	begin
		if (!csN)
		begin
			if (byteEnd)
			begin
				txShift = nextTx;
				byteEnd = 1'b0;
			end
			else
			begin
				txShift = {txShift[6:0], 1'b0};
			end
		end
	end

	assign miso = csN ? 1'bz : txShift[7];	// Released when not framed

endmodule

`default_nettype wire

//--- tests/SfmTb.sv
// Testbench for the serial flash front end with APB stimulus, three flash models and checks
`timescale 1ns/1ps
`default_nettype none

`include "sfm_macros.svh"

module SfmTb;

	localparam int clkPeriod   = 10;
	localparam int numXfers    = 2 * `SFM_NUM;
	localparam int maxPolls    = 16 * 256 / 4 + 16;
	localparam int limitCycles = numXfers * 16 * 256 + 2000;	// Worst case divisor plus APB time
	localparam int numReadable = 11;
	localparam SfmPkg::csrAdrsT readable [numReadable] = '{`SFM_REG_DIV, `SFM_REG_WD0,
		`SFM_REG_WD1, `SFM_REG_WD2, `SFM_REG_EN, `SFM_REG_CS, `SFM_REG_DONE, `SFM_REG_SEL,
		`SFM_REG_RD0, `SFM_REG_RD1, `SFM_REG_RD2};

	logic						iSCLK;
	logic						iSRST;
	logic						psel;
	logic						penable;
	logic						pwrite;
	SfmPkg::csrAdrsT			paddr;
	SfmPkg::apbDataT			pwdata;
	SfmPkg::apbDataT			prdata;
	logic						pready;
	logic						pslverr;
	logic						sclk;
	logic						mosi;
	logic [`SFM_NUM-1:0]		csN;
	tri0						miso;	// Pulls low when no flash is framed

	SfmPkg::sfmByteT			lastRx [`SFM_NUM];
	int							rxCount [`SFM_NUM];
	int							errCount = 0;
	int							checkCount = 0;
	SfmPkg::apbDataT			divWord;
	SfmPkg::sfmByteT			prevWd [`SFM_NUM];
	int							sent [`SFM_NUM];
	SfmPkg::apbDataT			snap [numReadable];
	SfmPkg::apbDataT			data;
	logic						err;

	SfmTop dut0 (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.sclk(sclk), .mosi(mosi), .csN(csN), .miso(miso)
	);

	for (genvar i = 0; i < `SFM_NUM; i++)
	begin : gFlash
		SfmFlashModel uFlash (
			.csN(csN[i]), .sclk(sclk), .mosi(mosi), .miso(miso),
			.lastRx(lastRx[i]), .rxCount(rxCount[i])
		);
	end

	initial
	begin
		iSCLK = 1'b0;
		forever #(clkPeriod / 2) iSCLK = ~iSCLK;
	end

	initial
	begin
		#(limitCycles * clkPeriod);
		$display("Watchdog expired before the tests finished");
		$display("Done: errors found");
		$finish;
	end

	// --------------------------------------------------
	// Bus protocol checks
	// --------------------------------------------------
	apbNoWait: assert property (@(posedge iSCLK) disable iff (iSRST)
		(psel && penable) |-> pready)
		else
		begin
			errCount++;
			$display("APB access phase seen without pready");
		end

	errReadZero: assert property (@(posedge iSCLK) disable iff (iSRST)
		(psel && penable && !pwrite && pslverr) |-> (prdata == '0))
		else
		begin
			errCount++;
			$display("Mismatch prdata: got 0x%h, expected 0x00000000", prdata);
		end

	// --------------------------------------------------
	// Tasks
	// --------------------------------------------------
	task automatic checkValue(input string name, input SfmPkg::apbDataT got,
		input SfmPkg::apbDataT exp);
		checkCount++;
		valueMatch: assert (got === exp)
		else
		begin
			errCount++;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic apbAccess(input logic write, input SfmPkg::csrAdrsT adrs,
		input SfmPkg::apbDataT wdata, output SfmPkg::apbDataT rdata, output logic slvErr);
		@(posedge iSCLK);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= adrs;
		pwdata  <= wdata;
		@(posedge iSCLK);
		penable <= 1'b1;
		@(negedge iSCLK);		// Mid access phase
		rdata  = prdata;
		slvErr = pslverr;
		@(posedge iSCLK);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input SfmPkg::csrAdrsT adrs, input SfmPkg::apbDataT wdata,
		output logic slvErr);
		SfmPkg::apbDataT unused;
		apbAccess(1'b1, adrs, wdata, unused, slvErr);
	endtask

	task automatic apbRead(input SfmPkg::csrAdrsT adrs, output SfmPkg::apbDataT rdata,
		output logic slvErr);
		apbAccess(1'b0, adrs, '0, rdata, slvErr);
	endtask

	// Only the selected device may follow its level
	task automatic checkChipSelects(input int sel, input logic [`SFM_NUM-1:0] levels);
		logic [`SFM_NUM-1:0] exp;
		exp = '1;
		if (sel < `SFM_NUM)
			exp[sel] = levels[sel];
		@(negedge iSCLK);
		checkValue("csN", csN, exp);
	endtask

	function automatic SfmPkg::csrAdrsT wdOffset(input int ch);
		case (ch)
			0:			return `SFM_REG_WD0;
			1:			return `SFM_REG_WD1;
			default:	return `SFM_REG_WD2;
		endcase
	endfunction

	function automatic SfmPkg::csrAdrsT rdOffset(input int ch);
		case (ch)
			0:			return `SFM_REG_RD0;
			1:			return `SFM_REG_RD1;
			default:	return `SFM_REG_RD2;
		endcase
	endfunction

	task automatic runTransfer(input int ch);
		SfmPkg::sfmByteT	wd;
		SfmPkg::sfmDivT		div;
		SfmPkg::sfmByteT	expRd;
		SfmPkg::apbDataT	rdata;
		logic				slvErr;
		int					polls;
		wd    = SfmPkg::sfmByteT'($urandom);
		div   = SfmPkg::sfmDivT'($urandom % 4);
		expRd = (sent[ch] == 0) ? 8'hA5 : ~prevWd[ch];	// Flash answers the last byte inverted
		divWord[8*ch +: 8] = div;
		apbWrite(wdOffset(ch), wd, slvErr);
		apbWrite(`SFM_REG_DIV, divWord, slvErr);
		apbWrite(`SFM_REG_DONE, 0, slvErr);		// Sticky bit of the previous byte
		apbWrite(`SFM_REG_EN, 1 << ch, slvErr);
		apbRead(`SFM_REG_EN, rdata, slvErr);
		checkValue("EN busy bit", rdata[ch], 1'b1);
		polls = 0;
		rdata = '0;
		while (!rdata[ch] && polls < maxPolls)
		begin
			apbRead(`SFM_REG_DONE, rdata, slvErr);
			checkChipSelects(ch, '0);
			polls++;
		end
		if (!rdata[ch])
		begin
			errCount++;
			$display("DONE bit of channel %0d never set", ch);
		end
		apbRead(`SFM_REG_EN, rdata, slvErr);
		checkValue("EN bit after done", rdata[ch], 1'b0);
		apbRead(rdOffset(ch), rdata, slvErr);
		checkValue($sformatf("RD%0d", ch), rdata, expRd);
		sent[ch]++;
		prevWd[ch] = wd;
		checkValue("flash received byte", lastRx[ch], wd);
		checkValue("flash byte count", rxCount[ch], sent[ch]);
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial
	begin
		void'($urandom(63));
		iSRST   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		divWord = 32'h0004_0404;
		for (int i = 0; i < `SFM_NUM; i++)
		begin
			prevWd[i] = '0;
			sent[i]   = 0;
		end
		repeat (5) @(posedge iSCLK);
		iSRST <= 1'b0;

		// Reset values
		checkChipSelects(`SFM_NUM, '1);
		checkValue("sclk", sclk, 1'b0);
		apbRead(`SFM_REG_DIV, data, err);
		checkValue("DIV", data, 32'h0004_0404);
		apbRead(`SFM_REG_CS, data, err);
		checkValue("CS", data, 32'h7);
		apbRead(`SFM_REG_EN, data, err);
		checkValue("EN", data, 0);
		apbRead(`SFM_REG_DONE, data, err);
		checkValue("DONE", data, 0);
		apbRead(`SFM_REG_SEL, data, err);
		checkValue("SEL", data, 0);
		checkValue("pslverr", err, 1'b0);

		for (int ch = 0; ch < `SFM_NUM; ch++)
		begin
			apbWrite(`SFM_REG_SEL, ch, err);
			apbWrite(`SFM_REG_CS, 0, err);		// All levels low, selected one framed only
			checkChipSelects(ch, '0);
			runTransfer(ch);
			runTransfer(ch);
			apbWrite(`SFM_REG_DONE, 0, err);
			apbRead(`SFM_REG_DONE, data, err);
			checkValue("DONE after clear", data, 0);
		end
		apbWrite(`SFM_REG_CS, 32'h7, err);
		checkChipSelects(`SFM_NUM, '1);

		// Unmapped offset
		apbRead(8'h40, data, err);
		checkValue("pslverr", err, 1'b1);
		checkValue("prdata", data, 0);
		for (int k = 0; k < numReadable; k++)
			apbRead(readable[k], snap[k], err);
		apbWrite(8'h40, 32'hFFFF_FFFF, err);
		checkValue("pslverr", err, 1'b1);
		for (int k = 0; k < numReadable; k++)
		begin
			apbRead(readable[k], data, err);
			checkValue($sformatf("register 0x%h", readable[k]), data, snap[k]);
		end

		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/SfmPkg.sv
csr/SfmCsr.sv
channel/SfmByteEngine.sv
source/SfmPinMux.sv
source/SfmTop.sv
tests/SfmFlashModel.sv
tests/SfmTb.sv

//--- Bender.yml
package:
  name: sfm

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/SfmPkg.sv
      - csr/SfmCsr.sv
      - channel/SfmByteEngine.sv
      - source/SfmPinMux.sv
      - source/SfmTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/SfmFlashModel.sv
      - tests/SfmTb.sv
